// ==== logic/axi_read_defs.svh ====
`ifndef AXI_READ_DEFS_SVH
`define AXI_READ_DEFS_SVH

// AXI field widths on the read channels
`define AXI_ADDR_W 32
`define AXI_DATA_W 32
`define AXI_ID_W 4

// Size code 2 is four bytes, the full data bus
`define AXI_MAX_SIZE 2

// Capture memory, one byte per entry
`define MEM_DEPTH 4096
`define MEM_ADDR_W 12

`endif

// ==== logic/axi_read_pkg.sv ====
`include "axi_read_defs.svh"

package axi_read_pkg;

        typedef logic [`AXI_ADDR_W-1:0] addr_t;
        typedef logic [`AXI_DATA_W-1:0] data_t;
        typedef logic [7:0] byte_t;
        typedef logic [`AXI_ID_W-1:0] id_t;
        typedef logic [3:0] len_t;      // Beats minus one
        typedef logic [2:0] size_t;     // Log2 of the beat bytes
        typedef logic [1:0] resp_t;
        typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;

        // Encodings follow ARBURST, code 3 is reserved
        typedef enum logic [1:0] {
                FIXED = 2'b00,
                INCR  = 2'b01,
                WRAP  = 2'b10
        } burst_e;

        typedef enum logic [1:0] {
                IDLE,
                ADDR,
                DATA,
                DONE
        } seq_state_e;

endpackage

// ==== logic/burst_decode.sv ====
`include "axi_read_defs.svh"

module burst_decode (
        input  logic                   clk,
        input  logic                   reset,
        input  logic                   cmd_valid,
        input  axi_read_pkg::id_t      cmd_id,
        input  axi_read_pkg::addr_t    cmd_addr,
        input  axi_read_pkg::len_t     cmd_len,
        input  axi_read_pkg::size_t    cmd_size,
        input  logic [1:0]             cmd_burst,
        input  logic                   seq_idle,
        output logic                   cmd_ready,
        output logic                   cmd_error,
        output logic                   dec_valid,
        output axi_read_pkg::id_t      dec_id,
        output axi_read_pkg::addr_t    dec_addr,
        output axi_read_pkg::len_t     dec_len,
        output axi_read_pkg::size_t    dec_size,
        output axi_read_pkg::burst_e   dec_burst,
        output logic [2:0]             beat_bytes,
        output axi_read_pkg::addr_t    wrap_mask
);

        logic                  cmd_fire;
        logic                  size_bad;
        logic                  burst_bad;
        logic                  wrap_len_bad;
        logic                  wrap_align_bad;
        logic                  cmd_illegal;
        axi_read_pkg::addr_t   align_mask;
        axi_read_pkg::addr_t   block_bytes;

        assign cmd_ready = seq_idle && !dec_valid;      // One burst in flight at a time
        assign cmd_fire  = cmd_valid && cmd_ready;

        assign size_bad  = cmd_size > `AXI_MAX_SIZE;
        assign burst_bad = cmd_burst == 2'b11;

        assign align_mask  = (axi_read_pkg::addr_t'(1) << cmd_size) - axi_read_pkg::addr_t'(1);
        assign block_bytes = (axi_read_pkg::addr_t'(cmd_len) + axi_read_pkg::addr_t'(1)) << cmd_size;

        // A wrap block must be a power of two beats and start on a beat boundary
        always_comb begin
                wrap_len_bad   = 1'b0;
                wrap_align_bad = 1'b0;
                if (cmd_burst == axi_read_pkg::WRAP) begin
                        case (cmd_len)
                                4'd1, 4'd3, 4'd7, 4'd15: wrap_len_bad = 1'b0;
                                default:                 wrap_len_bad = 1'b1;
                        endcase
                        wrap_align_bad = (cmd_addr & align_mask) != '0;
                end
        end

        assign cmd_illegal = size_bad || burst_bad || wrap_len_bad || wrap_align_bad;

        always_ff @(posedge clk or negedge reset) begin
                if (!reset) begin
                        dec_valid <= 1'b0;
                        cmd_error <= 1'b0;
                end else begin
                        cmd_error <= cmd_fire && cmd_illegal;   // Illegal command is dropped here
                        if (cmd_fire && !cmd_illegal)
                                dec_valid <= 1'b1;
                        else if (seq_idle)
                                dec_valid <= 1'b0;
                end
        end

        always_ff @(posedge clk) begin
                if (cmd_fire) begin
                        dec_id     <= cmd_id;
                        dec_addr   <= cmd_addr;
                        dec_len    <= cmd_len;
                        dec_size   <= cmd_size;
                        dec_burst  <= axi_read_pkg::burst_e'(cmd_burst);
                        beat_bytes <= 3'd1 << cmd_size;
                        wrap_mask  <= (cmd_burst == axi_read_pkg::WRAP) ?
                                      block_bytes - axi_read_pkg::addr_t'(1) : '0;
                end
        end

endmodule

// ==== logic/read_sequencer.sv ====
module read_sequencer (
        input  logic                               clk,
        input  logic                               reset,
        input  logic                               dec_valid,
        input  axi_read_pkg::id_t                  dec_id,
        input  axi_read_pkg::addr_t                dec_addr,
        input  axi_read_pkg::len_t                 dec_len,
        input  axi_read_pkg::size_t                dec_size,
        input  axi_read_pkg::burst_e               dec_burst,
        input  logic [2:0]                         beat_bytes,
        input  axi_read_pkg::addr_t                wrap_mask,
        output logic                               seq_idle,
        output logic                               arvalid,
        input  logic                               arready,
        output axi_read_pkg::id_t                  arid,
        output axi_read_pkg::addr_t                araddr,
        output axi_read_pkg::len_t                 arlen,
        output axi_read_pkg::size_t                arsize,
        output logic [1:0]                         arburst,
        input  logic                               rvalid,
        input  axi_read_pkg::data_t                rdata,
        input  axi_read_pkg::resp_t                rresp,
        input  logic                               rlast,
        output logic                               rready,
        output logic [3:0]                         lane_we,
        output axi_read_pkg::mem_addr_t [3:0]      lane_addr,
        output axi_read_pkg::data_t                lane_data,
        output axi_read_pkg::resp_t                beat_resp,
        output logic                               beat_last,
        output axi_read_pkg::id_t                  burst_id
);

        axi_read_pkg::seq_state_e   state;
        axi_read_pkg::seq_state_e   state_next;
        axi_read_pkg::burst_e       burst_q;
        logic [2:0]                 bytes_q;
        axi_read_pkg::addr_t        mask_q;
        axi_read_pkg::addr_t        base_addr;
        axi_read_pkg::addr_t        base_step;
        axi_read_pkg::addr_t        base_next;
        logic                       take_desc;
        logic                       beat_fire;

        assign take_desc = (state == axi_read_pkg::IDLE) && dec_valid;
        assign beat_fire = (state == axi_read_pkg::DATA) && rvalid;

        always_comb begin
                state_next = state;
                case (state)
                        axi_read_pkg::IDLE: begin
                                if (dec_valid)
                                        state_next = axi_read_pkg::ADDR;
                        end
                        axi_read_pkg::ADDR: begin
                                if (arready)
                                        state_next = axi_read_pkg::DATA;
                        end
                        axi_read_pkg::DATA: begin
                                if (rvalid && rlast)
                                        state_next = axi_read_pkg::DONE;
                        end
                        default: state_next = axi_read_pkg::IDLE;     // DONE lasts one cycle
                endcase
        end

        always_ff @(posedge clk or negedge reset) begin
                if (!reset)
                        state <= axi_read_pkg::IDLE;
                else
                        state <= state_next;
        end

        assign seq_idle = state == axi_read_pkg::IDLE;
        assign arvalid  = state == axi_read_pkg::ADDR;  // Fields below stay put until arready
        assign rready   = state == axi_read_pkg::DATA;

        // Next beat base per burst type
        assign base_step = base_addr + axi_read_pkg::addr_t'(bytes_q);

        always_comb begin
                case (burst_q)
                        axi_read_pkg::FIXED: base_next = base_addr;
                        axi_read_pkg::WRAP:  base_next = (base_addr & ~mask_q) | (base_step & mask_q);
                        default:             base_next = base_step;
                endcase
        end

        always_ff @(posedge clk) begin
                if (take_desc) begin
                        arid      <= dec_id;
                        araddr    <= dec_addr;
                        arlen     <= dec_len;
                        arsize    <= dec_size;
                        burst_q   <= dec_burst;
                        bytes_q   <= beat_bytes;
                        mask_q    <= wrap_mask;
                        base_addr <= dec_addr;
                end else if (beat_fire) begin
                        base_addr <= base_next;
                end
        end

        assign arburst = burst_q;

        // Byte address of each data lane, folded back into the wrap block when needed
        for (genvar k = 0; k < 4; k++) begin : g_lane
                axi_read_pkg::addr_t lane_byte;
                axi_read_pkg::addr_t lane_wrap;

                assign lane_byte    = base_addr + axi_read_pkg::addr_t'(k);
                assign lane_wrap    = (base_addr & ~mask_q) | (lane_byte & mask_q);
                assign lane_addr[k] = (burst_q == axi_read_pkg::WRAP) ?
                                      axi_read_pkg::mem_addr_t'(lane_wrap) :
                                      axi_read_pkg::mem_addr_t'(lane_byte);
                assign lane_we[k]   = beat_fire && (k < bytes_q);
        end

        assign lane_data = rdata;
        assign beat_resp = rresp;
        assign beat_last = beat_fire && rlast;
        assign burst_id  = arid;

endmodule

// ==== logic/capture_memory.sv ====
`include "axi_read_defs.svh"

module capture_memory (
        input  logic                               clk,
        input  logic                               reset,
        input  logic [3:0]                         lane_we,
        input  axi_read_pkg::mem_addr_t [3:0]      lane_addr,
        input  axi_read_pkg::data_t                lane_data,
        input  axi_read_pkg::resp_t                beat_resp,
        input  logic                               beat_last,
        input  axi_read_pkg::id_t                  burst_id,
        input  axi_read_pkg::mem_addr_t            mem_raddr,
        output axi_read_pkg::byte_t                mem_rdata,
        output logic                               done,
        output axi_read_pkg::id_t                  done_id,
        output axi_read_pkg::resp_t                done_resp
);

        axi_read_pkg::byte_t   mem [`MEM_DEPTH];
        axi_read_pkg::resp_t   worst_resp;
        axi_read_pkg::resp_t   beat_worst;
        logic                  beat_fire;

        assign beat_fire  = |lane_we;   // Lane 0 is written on every beat
        assign beat_worst = (beat_resp > worst_resp) ? beat_resp : worst_resp;

        always_ff @(posedge clk) begin
                for (int k = 0; k < 4; k++) begin
                        if (lane_we[k])
                                mem[lane_addr[k]] <= lane_data[8*k +: 8];
                end
                mem_rdata <= mem[mem_raddr];
        end

        // Highest response code seen so far counts as the worst
        always_ff @(posedge clk or negedge reset) begin
                if (!reset) begin
                        done       <= 1'b0;
                        worst_resp <= '0;
                end else begin
                        done <= beat_last;
                        if (beat_last)
                                worst_resp <= '0;
                        else if (beat_fire)
                                worst_resp <= beat_worst;
                end
        end

        always_ff @(posedge clk) begin
                if (beat_last) begin
                        done_id   <= burst_id;
                        done_resp <= beat_worst;
                end
        end

endmodule

// ==== logic/axi_read_master.sv ====
module axi_read_master (
        input  logic                       clk,
        input  logic                       reset,
        input  logic                       cmd_valid,
        input  axi_read_pkg::id_t          cmd_id,
        input  axi_read_pkg::addr_t        cmd_addr,
        input  axi_read_pkg::len_t         cmd_len,
        input  axi_read_pkg::size_t        cmd_size,
        input  logic [1:0]                 cmd_burst,
        output logic                       cmd_ready,
        output logic                       cmd_error,
        output logic                       arvalid,
        input  logic                       arready,
        output axi_read_pkg::id_t          arid,
        output axi_read_pkg::addr_t        araddr,
        output axi_read_pkg::len_t         arlen,
        output axi_read_pkg::size_t        arsize,
        output logic [1:0]                 arburst,
        input  logic                       rvalid,
        input  axi_read_pkg::data_t        rdata,
        input  axi_read_pkg::resp_t        rresp,
        input  logic                       rlast,
        output logic                       rready,
        input  axi_read_pkg::mem_addr_t    mem_raddr,
        output axi_read_pkg::byte_t        mem_rdata,
        output logic                       done,
        output axi_read_pkg::id_t          done_id,
        output axi_read_pkg::resp_t        done_resp
);

        logic                              seq_idle;
        logic                              dec_valid;
        axi_read_pkg::id_t                 dec_id;
        axi_read_pkg::addr_t               dec_addr;
        axi_read_pkg::len_t                dec_len;
        axi_read_pkg::size_t               dec_size;
        axi_read_pkg::burst_e              dec_burst;
        logic [2:0]                        beat_bytes;
        axi_read_pkg::addr_t               wrap_mask;
        logic [3:0]                        lane_we;
        axi_read_pkg::mem_addr_t [3:0]     lane_addr;
        axi_read_pkg::data_t               lane_data;
        axi_read_pkg::resp_t               beat_resp;
        logic                              beat_last;
        axi_read_pkg::id_t                 burst_id;

        burst_decode i_decode (
                .clk, .reset,
                .cmd_valid, .cmd_id, .cmd_addr, .cmd_len, .cmd_size, .cmd_burst,
                .seq_idle, .cmd_ready, .cmd_error,
                .dec_valid, .dec_id, .dec_addr, .dec_len, .dec_size, .dec_burst,
                .beat_bytes, .wrap_mask
        );

        read_sequencer i_sequencer (
                .clk, .reset,
                .dec_valid, .dec_id, .dec_addr, .dec_len, .dec_size, .dec_burst,
                .beat_bytes, .wrap_mask, .seq_idle,
                .arvalid, .arready, .arid, .araddr, .arlen, .arsize, .arburst,
                .rvalid, .rdata, .rresp, .rlast, .rready,
                .lane_we, .lane_addr, .lane_data, .beat_resp, .beat_last, .burst_id
        );

        capture_memory i_capture (
                .clk, .reset,
                .lane_we, .lane_addr, .lane_data, .beat_resp, .beat_last, .burst_id,
                .mem_raddr, .mem_rdata,
                .done, .done_id, .done_resp
        );

endmodule

// ==== test/axi_slave_model.sv ====
module axi_slave_model (
        input  logic                   clk,
        input  logic                   reset,
        input  logic                   arvalid,
        output logic                   arready,
        input  axi_read_pkg::id_t      arid,
        input  axi_read_pkg::len_t     arlen,
        output logic                   rvalid,
        output axi_read_pkg::data_t    rdata,
        output axi_read_pkg::resp_t    rresp,
        output logic                   rlast,
        input  logic                   rready
);

        logic [31:0]            data_state;
        logic [31:0]            gap_state;
        logic                   busy;
        logic                   r_fire;
        logic [1:0]             gap;
        axi_read_pkg::len_t     beat_n;

        function automatic logic [31:0] xorshift32(input logic [31:0] x);
                logic [31:0] y;
                y = x ^ (x << 13);
                y = y ^ (y >> 17);
                return y ^ (y << 5);
        endfunction

        always @(posedge clk or negedge reset) begin
                if (!reset)
                        r_fire <= 1'b0;
                else
                        r_fire <= rvalid && rready;     // Beat taken on this edge
        end

        // Responses change on the falling edge and the DUT samples them on the rising one
        always @(negedge clk or negedge reset) begin
                if (!reset) begin
                        arready    <= 1'b0;
                        rvalid     <= 1'b0;
                        rdata      <= '0;
                        rresp      <= '0;
                        rlast      <= 1'b0;
                        busy       <= 1'b0;
                        gap        <= 2'd0;
                        beat_n     <= '0;
                        data_state <= 32'h9296;
                        gap_state  <= 32'h9296;
                end else begin
                        arready   <= 1'b0;
                        gap_state <= xorshift32(gap_state);
                        if (!busy) begin
                                if (arvalid && gap == 2'd0) begin
                                        arready <= 1'b1;
                                        busy    <= 1'b1;
                                        beat_n  <= '0;
                                        gap     <= gap_state[1:0];
                                end else if (arvalid) begin
                                        gap <= gap - 2'd1;
                                end
                        end else if (r_fire) begin
                                rvalid <= 1'b0;
                                beat_n <= beat_n + 4'd1;
                                gap    <= gap_state[1:0];
                                busy   <= !rlast;
                        end else if (!rvalid) begin
                                if (gap == 2'd0) begin
                                        rvalid     <= 1'b1;
                                        rdata      <= xorshift32(data_state);
                                        data_state <= xorshift32(data_state);
                                        // SLVERR on the third beat of id E
                                        rresp      <= (arid == 4'hE && beat_n == 4'd2) ? 2'b10 : 2'b00;
                                        rlast      <= beat_n == arlen;
                                end else begin
                                        gap <= gap - 2'd1;
                                end
                        end
                end
        end

endmodule

// ==== test/axi_read_master_tb.sv ====
`include "axi_read_defs.svh"

module axi_read_master_tb;

        localparam int NUM_CMDS = 11;
        localparam int TIMEOUT  = 200;

        typedef struct packed {
                axi_read_pkg::id_t      id;
                axi_read_pkg::addr_t    addr;
                axi_read_pkg::len_t     len;
                axi_read_pkg::size_t    size;
                logic [1:0]             burst;
                logic                   expect_error;
        } cmd_entry_t;

        logic                       clk;
        logic                       reset;
        logic                       cmd_valid;
        axi_read_pkg::id_t          cmd_id;
        axi_read_pkg::addr_t        cmd_addr;
        axi_read_pkg::len_t         cmd_len;
        axi_read_pkg::size_t        cmd_size;
        logic [1:0]                 cmd_burst;
        logic                       cmd_ready;
        logic                       cmd_error;
        logic                       arvalid;
        logic                       arready;
        axi_read_pkg::id_t          arid;
        axi_read_pkg::addr_t        araddr;
        axi_read_pkg::len_t         arlen;
        axi_read_pkg::size_t        arsize;
        logic [1:0]                 arburst;
        logic                       rvalid;
        axi_read_pkg::data_t        rdata;
        axi_read_pkg::resp_t        rresp;
        logic                       rlast;
        logic                       rready;
        axi_read_pkg::mem_addr_t    mem_raddr;
        axi_read_pkg::byte_t        mem_rdata;
        logic                       done;
        axi_read_pkg::id_t          done_id;
        axi_read_pkg::resp_t        done_resp;

        cmd_entry_t                 cmd_table [NUM_CMDS];
        axi_read_pkg::byte_t        shadow [`MEM_DEPTH];        // Unwritten bytes stay X
        logic [31:0]                mirror_state;
        logic                       run_ok;
        int                         mismatches;
        int                         protocol_errors;
        int                         timeouts;

        axi_read_master i_dut (
                .clk, .reset,
                .cmd_valid, .cmd_id, .cmd_addr, .cmd_len, .cmd_size, .cmd_burst,
                .cmd_ready, .cmd_error,
                .arvalid, .arready, .arid, .araddr, .arlen, .arsize, .arburst,
                .rvalid, .rdata, .rresp, .rlast, .rready,
                .mem_raddr, .mem_rdata, .done, .done_id, .done_resp
        );

        axi_slave_model i_slave (
                .clk, .reset, .arvalid, .arready, .arid, .arlen,
                .rvalid, .rdata, .rresp, .rlast, .rready
        );

        function automatic logic [31:0] xorshift32(input logic [31:0] x);
                logic [31:0] y;
                y = x ^ (x << 13);
                y = y ^ (y >> 17);
                return y ^ (y << 5);
        endfunction

        task automatic check_byte(input axi_read_pkg::byte_t actual,
                                  input axi_read_pkg::byte_t expected,
                                  input axi_read_pkg::mem_addr_t addr);
                if (actual !== expected) begin
                        $display("Fail at time %0t: byte 0x%03h expected %02h, got %02h",
                                 $time, addr, expected, actual);
                        mismatches++;
                end
        endtask

        task automatic check_resp(input axi_read_pkg::resp_t actual,
                                  input axi_read_pkg::resp_t expected, input int index);
                if (actual !== expected) begin
                        $display("Fail at time %0t: command %0d done_resp expected %0d, got %0d",
                                 $time, index, expected, actual);
                        mismatches++;
                end
        endtask

        task automatic check_id(input axi_read_pkg::id_t actual,
                                input axi_read_pkg::id_t expected, input int index);
                if (actual !== expected) begin
                        $display("Fail at time %0t: command %0d done_id expected %0h, got %0h",
                                 $time, index, expected, actual);
                        mismatches++;
                end
        endtask

        // The AR request carries the accepted command fields unchanged
        task automatic check_ar(input axi_read_pkg::id_t id, input axi_read_pkg::addr_t addr,
                                input axi_read_pkg::len_t len, input axi_read_pkg::size_t size,
                                input logic [1:0] burst, input cmd_entry_t c, input int index);
                if (id !== c.id || addr !== c.addr || len !== c.len || size !== c.size ||
                    burst !== c.burst) begin
                        $display("Fail at time %0t: command %0d AR fields expected %h, got %h",
                                 $time, index, {c.id, c.addr, c.len, c.size, c.burst},
                                 {id, addr, len, size, burst});
                        mismatches++;
                end
        endtask

        // Replays the slave data stream and places each lane by the burst address rules
        task automatic apply_to_shadow(input cmd_entry_t c);
                axi_read_pkg::addr_t    byte_addr;
                axi_read_pkg::addr_t    wrap_base;
                axi_read_pkg::data_t    beat_data;
                int                     beat_bytes;
                int                     block;
                int                     offset;
                int                     step;
                beat_bytes = 1 << c.size;
                block      = (c.len + 1) * beat_bytes;
                wrap_base  = c.addr - (c.addr % block);
                offset     = c.addr - wrap_base;
                for (int n = 0; n <= c.len; n++) begin
                        mirror_state = xorshift32(mirror_state);
                        beat_data    = mirror_state;
                        step         = n * beat_bytes;
                        for (int k = 0; k < beat_bytes; k++) begin
                                if (c.burst == axi_read_pkg::FIXED)
                                        byte_addr = c.addr + k;
                                else if (c.burst == axi_read_pkg::WRAP)
                                        byte_addr = wrap_base + (offset + step + k) % block;
                                else
                                        byte_addr = c.addr + step + k;
                                shadow[byte_addr[`MEM_ADDR_W-1:0]] = beat_data[8*k +: 8];
                        end
                end
        endtask

        task automatic check_region(input axi_read_pkg::mem_addr_t first, input int count);
                axi_read_pkg::mem_addr_t a;
                for (int i = 0; i < count; i++) begin
                        a         = first + i[`MEM_ADDR_W-1:0];
                        mem_raddr = a;
                        @(negedge clk);         // One cycle of read latency
                        check_byte(mem_rdata, shadow[a], a);
                end
        endtask

        task automatic wait_ready(input int index, output logic ok);
                ok = 1'b0;
                for (int cnt = 0; cnt < TIMEOUT; cnt++) begin
                        if (cmd_ready) begin
                                ok = 1'b1;
                                break;
                        end
                        @(negedge clk);
                end
                if (!ok) begin
                        $display("Timeout: cmd_ready never rose before command %0d", index);
                        timeouts++;
                end
        endtask

        task automatic wait_result(input cmd_entry_t c, input int index, output logic ok);
                ok = 1'b0;
                for (int cnt = 0; cnt < TIMEOUT; cnt++) begin
                        if (c.expect_error ? cmd_error : done) begin
                                ok = 1'b1;
                                break;
                        end
                        if (!c.expect_error && cmd_error) begin
                                $display("Command %0d is legal but raised cmd_error", index);
                                protocol_errors++;
                        end
                        if (!c.expect_error && cmd_ready) begin
                                $display("Command %0d is in flight but cmd_ready is high", index);
                                protocol_errors++;
                        end
                        if (arvalid)
                                check_ar(arid, araddr, arlen, arsize, arburst, c, index);
                        @(negedge clk);
                end
                if (!ok) begin
                        $display("Timeout: %s never arrived for command %0d",
                                 c.expect_error ? "cmd_error" : "done", index);
                        timeouts++;
                end else if (c.expect_error) begin
                        // arvalid would rise two cycles after acceptance
                        repeat (3) begin
                                @(negedge clk);
                                if (arvalid || done) begin
                                        $display("Command %0d is illegal but started a burst", index);
                                        protocol_errors++;
                                end
                        end
                end else begin
                        check_id(done_id, c.id, index);
                        check_resp(done_resp, (c.id == 4'hE && c.len >= 4'd2) ? 2'b10 : 2'b00,
                                   index);
                end
        endtask

        task automatic run_command(input int index, output logic ok);
                cmd_entry_t c;
                c = cmd_table[index];
                wait_ready(index, ok);
                if (ok) begin
                        cmd_valid = 1'b1;
                        cmd_id    = c.id;
                        cmd_addr  = c.addr;
                        cmd_len   = c.len;
                        cmd_size  = c.size;
                        cmd_burst = c.burst;
                        @(negedge clk);
                        cmd_valid = 1'b0;
                        if (!c.expect_error)
                                apply_to_shadow(c);
                        wait_result(c, index, ok);
                        if (ok)
                                check_region({c.addr[11:5], 5'b0}, 64);
                end
        endtask

        initial begin
                clk = 1'b0;
                forever #4 clk = ~clk;
        end

        initial begin
                reset           = 1'b1;
                cmd_valid       = 1'b0;
                cmd_id          = '0;
                cmd_addr        = '0;
                cmd_len         = '0;
                cmd_size        = '0;
                cmd_burst       = 2'b00;
                mem_raddr       = '0;
                mismatches      = 0;
                protocol_errors = 0;
                timeouts        = 0;
                mirror_state    = 32'h9296;
                run_ok          = 1'b1;

                // id, addr, len, size, burst, expect_error
                cmd_table[0]  = {4'h1, 32'h0000_0100, 4'd3,  3'd2, axi_read_pkg::INCR,  1'b0};
                cmd_table[1]  = {4'h2, 32'h0000_0205, 4'd5,  3'd0, axi_read_pkg::FIXED, 1'b0};
                cmd_table[2]  = {4'h3, 32'h0000_0306, 4'd3,  3'd1, axi_read_pkg::WRAP,  1'b0};
                cmd_table[3]  = {4'h4, 32'h0000_0414, 4'd7,  3'd2, axi_read_pkg::WRAP,  1'b0};
                cmd_table[4]  = {4'hE, 32'h0000_0500, 4'd3,  3'd2, axi_read_pkg::INCR,  1'b0};
                cmd_table[5]  = {4'h5, 32'h0000_0100, 4'd3,  3'd3, axi_read_pkg::INCR,  1'b1};
                cmd_table[6]  = {4'h6, 32'h0000_0300, 4'd3,  3'd1, 2'b11,               1'b1};
                cmd_table[7]  = {4'h7, 32'h0000_0400, 4'd2,  3'd2, axi_read_pkg::WRAP,  1'b1};
                cmd_table[8]  = {4'h8, 32'h0000_0402, 4'd3,  3'd2, axi_read_pkg::WRAP,  1'b1};
                cmd_table[9]  = {4'h9, 32'h0000_05FE, 4'd15, 3'd1, axi_read_pkg::INCR,  1'b0};
                cmd_table[10] = {4'hA, 32'h0000_0FFC, 4'd3,  3'd2, axi_read_pkg::INCR,  1'b0};

                #1 reset = 1'b0;        // Falling reset edge right after time zero resets every block
                repeat (8) @(negedge clk);
                reset = 1'b1;
                @(negedge clk);

                for (int i = 0; i < NUM_CMDS; i++) begin
                        run_command(i, run_ok);
                        if (!run_ok)
                                break;
                end
                if (run_ok)
                        check_region('0, `MEM_DEPTH);   // Also catches stray writes anywhere

                $display("Result: %0d mismatches, %0d protocol errors, %0d timeouts",
                         mismatches, protocol_errors, timeouts);
                if (mismatches == 0 && protocol_errors == 0 && timeouts == 0)
                        $display("=== PASS ===");
                else
                        $display("=== FAIL ===");
                $finish;
        end

endmodule

// ==== axi_read_master.f ====
+incdir+logic
logic/axi_read_pkg.sv
logic/burst_decode.sv
logic/read_sequencer.sv
logic/capture_memory.sv
logic/axi_read_master.sv
test/axi_slave_model.sv
test/axi_read_master_tb.sv

// ==== Bender.yml ====
package:
  name: axi_read_master

sources:
  - include_dirs:
      - logic
    files:
      - logic/axi_read_pkg.sv
      - logic/burst_decode.sv
      - logic/read_sequencer.sv
      - logic/capture_memory.sv
      - logic/axi_read_master.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/axi_slave_model.sv
      - test/axi_read_master_tb.sv
